// ==== logic/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

    localparam int WORD_W = 32;
    localparam int ADDR_W = 8;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [2*WORD_W-1:0] dword_t;   // {HI, LO}
    typedef logic [4:0]          shamt_t;
    typedef logic [ADDR_W-1:0]   apb_addr_t;

    // Operation codes as written to CMD
    typedef enum logic [5:0] {
        OP_NONE  = 6'd0,
        OP_OR    = 6'd1,
        OP_AND   = 6'd2,
        OP_NOR   = 6'd3,
        OP_XOR   = 6'd4,
        OP_SLL   = 6'd5,
        OP_SRL   = 6'd6,
        OP_SRA   = 6'd7,
        OP_ADD   = 6'd8,
        OP_ADDU  = 6'd9,
        OP_SUB   = 6'd10,
        OP_SUBU  = 6'd11,
        OP_SLT   = 6'd12,
        OP_SLTU  = 6'd13,
        OP_CLZ   = 6'd14,
        OP_CLO   = 6'd15,
        OP_MFHI  = 6'd16,
        OP_MFLO  = 6'd17,
        OP_MTHI  = 6'd18,
        OP_MTLO  = 6'd19,
        OP_MUL   = 6'd20,
        OP_MULT  = 6'd21,
        OP_MULTU = 6'd22,
        OP_MADD  = 6'd23,
        OP_MADDU = 6'd24,
        OP_MSUB  = 6'd25,
        OP_MSUBU = 6'd26
    } exu_op_e;

    typedef enum logic {
        MAC_IDLE,
        MAC_ACC
    } mac_state_e;

    // APB register map, byte offsets
    localparam apb_addr_t REG_OPA    = 8'h00;
    localparam apb_addr_t REG_OPB    = 8'h04;
    localparam apb_addr_t REG_CMD    = 8'h08;
    localparam apb_addr_t REG_RESULT = 8'h0C;
    localparam apb_addr_t REG_HI     = 8'h10;
    localparam apb_addr_t REG_LO     = 8'h14;
    localparam apb_addr_t REG_STATUS = 8'h18;

    localparam int STATUS_OVF_BIT = 0;

endpackage

`default_nettype wire

// ==== logic/exu_cmd_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface exu_cmd_if import exu_pkg::*; ();

    logic    issue;       // High from first access cycle of a CMD write until done
    exu_op_e op;
    word_t   opa;
    word_t   opb;

    logic    alu_hit;     // ALU owns op, result valid now
    word_t   alu_result;
    logic    alu_ovf;

    logic    mul_claim;   // Multiplier owns op
    logic    mul_done;
    word_t   mul_result;
    word_t   hi;
    word_t   lo;

    modport regs (output issue, op, opa, opb,
                  input  alu_hit, alu_result, alu_ovf,
                  input  mul_claim, mul_done, mul_result, hi, lo);

    modport alu  (input  issue, op, opa, opb, hi, lo,
                  output alu_hit, alu_result, alu_ovf);

    modport mul  (input  issue, op, opa, opb,
                  output mul_claim, mul_done, mul_result, hi, lo);

    // Observation only
    modport top  (input issue, op, opa, opb, alu_hit, alu_result, alu_ovf,
                  input mul_claim, mul_done, mul_result, hi, lo);

endinterface

`default_nettype wire

// ==== logic/apb_exu_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module apb_exu_regs import exu_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  word_t     pwdata_i,
    output word_t     prdata_o,
    output logic      pready_o,
    output logic      pslverr_o,
    exu_cmd_if.regs   cmd
);

    logic  access;
    logic  wr;
    logic  mapped;
    logic  pend_q;     // CMD access already past its first cycle
    logic  illegal;
    logic  cmd_done;
    word_t opa_q;
    word_t opb_q;
    word_t result_q;
    logic  ovf_q;
    word_t status_w;

    assign access = psel_i & penable_i;
    assign wr     = access & pwrite_i;

    // Command issue
    assign cmd.issue = wr & (paddr_i == REG_CMD);
    assign cmd.op    = (pwdata_i[31:6] == '0) ? exu_op_e'(pwdata_i[5:0]) : OP_NONE;
    assign cmd.opa   = opa_q;
    assign cmd.opb   = opb_q;

    // Nobody claimed in the first cycle
    assign illegal  = cmd.issue & ~pend_q & ~cmd.alu_hit & ~cmd.mul_claim;
    assign cmd_done = cmd.alu_hit | cmd.mul_done | illegal;

    assign pready_o  = ~cmd.issue | cmd_done;
    assign pslverr_o = access & pready_o & (~mapped | illegal);

    always_comb begin
        status_w                 = '0;
        status_w[STATUS_OVF_BIT] = ovf_q;
    end

    // Address decode and read mux
    always_comb begin
        mapped   = 1'b1;
        prdata_o = '0;
        case (paddr_i)
            REG_OPA:    prdata_o = opa_q;
            REG_OPB:    prdata_o = opb_q;
            REG_CMD:    prdata_o = '0;   // Write only
            REG_RESULT: prdata_o = result_q;
            REG_HI:     prdata_o = cmd.hi;
            REG_LO:     prdata_o = cmd.lo;
            REG_STATUS: prdata_o = status_w;
            default:    mapped   = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pend_q <= 1'b0;
        end else begin
            pend_q <= cmd.issue & ~pready_o;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            opa_q <= '0;
            opb_q <= '0;
        end else if (wr) begin
            if (paddr_i == REG_OPA) opa_q <= pwdata_i;
            if (paddr_i == REG_OPB) opb_q <= pwdata_i;
        end
    end

    // Result and overflow on completion
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_q <= '0;
            ovf_q    <= 1'b0;
        end else if (cmd.alu_hit) begin
            if (cmd.alu_ovf) begin
                ovf_q <= 1'b1;              // Keep old RESULT
            end else begin
                result_q <= cmd.alu_result;
                ovf_q    <= 1'b0;
            end
        end else if (cmd.mul_done) begin
            ovf_q <= 1'b0;
            if (cmd.op == OP_MUL) result_q <= cmd.mul_result;
        end
    end

endmodule

`default_nettype wire

// ==== logic/alu_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_core import exu_pkg::*; (
    exu_cmd_if.alu cmd
);

    shamt_t shamt;
    logic   is_sub;
    word_t  opb_mux;
    word_t  sum;
    logic   ovf;
    logic   lt_s;
    logic   lt_u;
    logic   own_op;
    word_t  res;

    // Leading zero count, 32 for an all-zero word
    function automatic word_t lead_zeros(input word_t w);
        word_t n;
        logic  seen;
        n    = '0;
        seen = 1'b0;
        for (int i = WORD_W - 1; i >= 0; i--) begin
            if (w[i]) begin
                seen = 1'b1;
            end else if (!seen) begin
                n = n + 32'd1;
            end
        end
        return n;
    endfunction

    assign shamt   = cmd.opa[4:0];
    assign is_sub  = (cmd.op == OP_SUB) || (cmd.op == OP_SUBU) || (cmd.op == OP_SLT);
    assign opb_mux = is_sub ? (~cmd.opb + 32'd1) : cmd.opb;   // Two's complement for sub
    assign sum     = cmd.opa + opb_mux;

    // Signed overflow, tested against the raw operand B
    assign ovf = is_sub ? ((cmd.opa[31] ^ cmd.opb[31]) & (sum[31] ^ cmd.opa[31]))
                        : (~(cmd.opa[31] ^ cmd.opb[31]) & (sum[31] ^ cmd.opa[31]));

    // Same signs cannot overflow, so the difference sign decides
    assign lt_s = (cmd.opa[31] & ~cmd.opb[31])
                | (~(cmd.opa[31] ^ cmd.opb[31]) & sum[31]);
    assign lt_u = cmd.opa < cmd.opb;

    assign own_op = (cmd.op >= OP_OR) && (cmd.op <= OP_MFLO);

    always_comb begin
        case (cmd.op)
            OP_OR:   res = cmd.opa | cmd.opb;
            OP_AND:  res = cmd.opa & cmd.opb;
            OP_NOR:  res = ~(cmd.opa | cmd.opb);
            OP_XOR:  res = cmd.opa ^ cmd.opb;
            OP_SLL:  res = cmd.opb << shamt;
            OP_SRL:  res = cmd.opb >> shamt;
            OP_SRA:  res = word_t'($signed(cmd.opb) >>> shamt);   // Sign fill
            OP_ADD, OP_ADDU,
            OP_SUB, OP_SUBU: res = sum;
            OP_SLT:  res = {{(WORD_W-1){1'b0}}, lt_s};
            OP_SLTU: res = {{(WORD_W-1){1'b0}}, lt_u};
            OP_CLZ:  res = lead_zeros(cmd.opa);
            OP_CLO:  res = lead_zeros(~cmd.opa);
            OP_MFHI: res = cmd.hi;
            OP_MFLO: res = cmd.lo;
            default: res = '0;
        endcase
    end

    assign cmd.alu_hit    = cmd.issue & own_op;
    assign cmd.alu_result = res;
    assign cmd.alu_ovf    = ovf & ((cmd.op == OP_ADD) || (cmd.op == OP_SUB));

endmodule

`default_nettype wire

// ==== logic/mul_acc_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module mul_acc_unit import exu_pkg::*; (
    input  logic   clk_i,
    input  logic   arst_n_i,
    exu_cmd_if.mul cmd
);

    mac_state_e state_q;
    word_t      hi_q;
    word_t      lo_q;
    dword_t     prod_q;      // Product held for the accumulate cycle
    logic       is_signed;
    logic       is_mac;
    logic       is_msub;
    logic       own_op;
    logic       claim;
    logic       neg;
    word_t      mag_a;
    word_t      mag_b;
    dword_t     mag_prod;
    dword_t     product;

    assign is_signed = (cmd.op == OP_MUL) || (cmd.op == OP_MULT)
                    || (cmd.op == OP_MADD) || (cmd.op == OP_MSUB);
    assign is_mac    = (cmd.op >= OP_MADD) && (cmd.op <= OP_MSUBU);
    assign is_msub   = (cmd.op == OP_MSUB) || (cmd.op == OP_MSUBU);
    assign own_op    = (cmd.op >= OP_MTHI) && (cmd.op <= OP_MSUBU);

    // Only accept a new command while idle
    assign claim = cmd.issue & own_op & (state_q == MAC_IDLE);

    // Multiply magnitudes then fix the sign
    assign mag_a    = (is_signed && cmd.opa[31]) ? (~cmd.opa + 32'd1) : cmd.opa;
    assign mag_b    = (is_signed && cmd.opb[31]) ? (~cmd.opb + 32'd1) : cmd.opb;
    assign mag_prod = dword_t'(mag_a) * dword_t'(mag_b);
    assign neg      = is_signed & (cmd.opa[31] ^ cmd.opb[31]);
    assign product  = neg ? (~mag_prod + 64'd1) : mag_prod;

    assign cmd.mul_claim  = claim;
    assign cmd.mul_done   = (state_q == MAC_ACC) | (claim & ~is_mac);
    assign cmd.mul_result = product[31:0];   // Low word for mul
    assign cmd.hi         = hi_q;
    assign cmd.lo         = lo_q;

    // msub keeps the negated product so the second cycle always adds
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prod_q <= '0;
        end else if (claim && is_mac) begin
            prod_q <= is_msub ? (~product + 64'd1) : product;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= MAC_IDLE;
            hi_q    <= '0;
            lo_q    <= '0;
        end else begin
            case (state_q)
                MAC_IDLE: begin
                    if (claim) begin
                        case (cmd.op)
                            OP_MULT, OP_MULTU: {hi_q, lo_q} <= product;
                            OP_MTHI: hi_q <= cmd.opa;
                            OP_MTLO: lo_q <= cmd.opa;
                            OP_MADD, OP_MADDU,
                            OP_MSUB, OP_MSUBU: state_q <= MAC_ACC;
                            default: begin
                            end
                        endcase
                    end
                end
                MAC_ACC: begin
                    {hi_q, lo_q} <= {hi_q, lo_q} + prod_q;   // Done this cycle
                    state_q      <= MAC_IDLE;
                end
                default: state_q <= MAC_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/exec_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_top import exu_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  word_t     pwdata_i,
    output word_t     prdata_o,
    output logic      pready_o,
    output logic      pslverr_o
);

    // Command and completion between the register block and the units
    exu_cmd_if cmd ();

    apb_exu_regs u_regs (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .cmd       (cmd)
    );

    // Single cycle ops and HI/LO reads
    alu_core u_alu (
        .cmd (cmd)
    );

    mul_acc_unit u_mul (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .cmd      (cmd)
    );

endmodule

`default_nettype wire

// ==== bench/exu_model.svh ====
`ifndef EXU_MODEL_SVH
`define EXU_MODEL_SVH

// Leading bits equal to val, 32 when the whole word matches
function automatic word_t lead_count(input word_t w, input logic val);
    word_t n;
    n = '0;
    for (int i = 31; i >= 0; i--) begin
        if (w[i] != val) break;
        n++;
    end
    return n;
endfunction

// Signed overflow of add and sub only
function automatic logic signed_ovf(input exu_op_e op, input word_t a, input word_t b);
    logic [32:0] wide;
    wide = '0;
    if (op == OP_ADD) begin
        wide = {a[31], a} + {b[31], b};
    end else if (op == OP_SUB) begin
        wide = {a[31], a} - {b[31], b};
    end
    return wide[32] != wide[31];
endfunction

function automatic word_t alu_expect(input exu_op_e op, input word_t a, input word_t b);
    dword_t ext;
    ext = {{32{b[31]}}, b} >> a[4:0];   // Sign filled shift
    case (op)
        OP_OR:           return a | b;
        OP_AND:          return a & b;
        OP_NOR:          return ~(a | b);
        OP_XOR:          return a ^ b;
        OP_SLL:          return b << a[4:0];
        OP_SRL:          return b >> a[4:0];
        OP_SRA:          return ext[31:0];
        OP_ADD, OP_ADDU: return a + b;
        OP_SUB, OP_SUBU: return a - b;
        OP_SLT:          return word_t'($signed(a) < $signed(b));
        OP_SLTU:         return word_t'(a < b);
        OP_CLZ:          return lead_count(a, 1'b0);
        OP_CLO:          return lead_count(a, 1'b1);
        default:         return '0;
    endcase
endfunction

// Low 64 bits of the extended operands give the full product
function automatic dword_t product(input logic sgn, input word_t a, input word_t b);
    dword_t xa;
    dword_t xb;
    xa = sgn ? {{32{a[31]}}, a} : {32'b0, a};
    xb = sgn ? {{32{b[31]}}, b} : {32'b0, b};
    return xa * xb;
endfunction

`endif

// ==== bench/tb_exec_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_exec_top import exu_pkg::*; ();

    localparam int MAX_WAIT = 16;   // Access cycles before giving up

    logic      clk;
    logic      arst_n;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    word_t     pwdata;
    word_t     prdata;
    logic      pready;
    logic      pslverr;

    integer seed = 32'h289534c6;
    int     n_checks = 0;
    word_t  m_opa;
    word_t  m_opb;
    word_t  m_result;
    word_t  m_hi;
    word_t  m_lo;
    logic   m_ovf;

    `include "exu_model.svh"

    exec_top uut (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort(input string why);
        $display("Some tests failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check(input string name, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
            abort("value mismatch");
        end
    endtask

    function automatic word_t pick_operand();
        word_t r;
        r = $random(seed);
        case (r[2:0])
            3'd0:    return 32'h0000_0000;
            3'd1:    return 32'hFFFF_FFFF;
            3'd2:    return 32'h8000_0000;
            3'd3:    return 32'h7FFF_FFFF;
            default: return $random(seed);
        endcase
    endfunction

    function automatic exu_op_e pick_op(input exu_op_e first, input int count);
        word_t code;
        code = word_t'(first) + $unsigned($random(seed)) % word_t'(count);
        return exu_op_e'(code[5:0]);
    endfunction

    // Setup cycle and access cycles until PREADY with sampling on the falling edge
    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input word_t wdata,
                            output word_t rdata, output logic err, output int waits);
        waits = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) begin
            waits++;
            if (waits > MAX_WAIT) abort("PREADY stayed low during an APB access");
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic reg_write(input apb_addr_t addr, input word_t data,
                             input logic exp_err, input int exp_waits);
        word_t rd;
        logic  err;
        int    waits;
        apb_xfer(1'b1, addr, data, rd, err, waits);
        check("pslverr", word_t'(err), word_t'(exp_err));
        check("wait_cycles", word_t'(waits), word_t'(exp_waits));
    endtask

    task automatic reg_read(input apb_addr_t addr, input word_t exp, input string name);
        word_t rd;
        logic  err;
        int    waits;
        apb_xfer(1'b0, addr, '0, rd, err, waits);
        check("pslverr", word_t'(err), '0);
        check("wait_cycles", word_t'(waits), '0);
        check(name, rd, exp);
    endtask

    task automatic verify_state();
        reg_read(REG_RESULT, m_result, "RESULT");
        reg_read(REG_HI, m_hi, "HI");
        reg_read(REG_LO, m_lo, "LO");
        reg_read(REG_STATUS, word_t'(m_ovf) << STATUS_OVF_BIT, "STATUS");
    endtask

    task automatic model_exec(input exu_op_e op, input word_t a, input word_t b);
        dword_t acc;
        dword_t p;
        acc   = {m_hi, m_lo};
        p     = product(op == OP_MUL || op == OP_MULT || op == OP_MADD || op == OP_MSUB,
                        a, b);
        m_ovf = signed_ovf(op, a, b);
        case (op)
            OP_MFHI:           m_result = m_hi;
            OP_MFLO:           m_result = m_lo;
            OP_MTHI:           m_hi = a;
            OP_MTLO:           m_lo = a;
            OP_MUL:            m_result = p[31:0];
            OP_MULT, OP_MULTU: {m_hi, m_lo} = p;
            OP_MADD, OP_MADDU: {m_hi, m_lo} = acc + p;
            OP_MSUB, OP_MSUBU: {m_hi, m_lo} = acc - p;
            default: begin
                if (!m_ovf) m_result = alu_expect(op, a, b);   // Overflow keeps RESULT
            end
        endcase
    endtask

    task automatic run_op(input exu_op_e op, input word_t a, input word_t b);
        int exp_waits;
        exp_waits = (op >= OP_MADD && op <= OP_MSUBU) ? 1 : 0;   // Accumulate stalls once
        reg_write(REG_OPA, a, 1'b0, 0);
        reg_write(REG_OPB, b, 1'b0, 0);
        m_opa = a;
        m_opb = b;
        reg_write(REG_CMD, word_t'(op), 1'b0, exp_waits);
        model_exec(op, a, b);
        verify_state();
    endtask

    // Expect an error response and no change of state
    task automatic bad_access(input logic wr, input apb_addr_t addr);
        word_t rd;
        logic  err;
        int    waits;
        apb_xfer(wr, addr, pick_operand(), rd, err, waits);
        check("pslverr", word_t'(err), 32'd1);
        verify_state();
        reg_read(REG_OPA, m_opa, "OPA");
        reg_read(REG_OPB, m_opb, "OPB");
    endtask

    initial begin
        word_t a;
        word_t v;
        arst_n   = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        m_opa    = '0;
        m_opb    = '0;
        m_result = '0;
        m_hi     = '0;
        m_lo     = '0;
        m_ovf    = 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        verify_state();

        repeat (40) run_op(pick_op(OP_OR, 7), pick_operand(), pick_operand());
        run_op(OP_ADD, 32'h7FFF_FFFF, 32'h0000_0001);
        run_op(OP_SUB, 32'h8000_0000, 32'h0000_0001);
        repeat (60) run_op(pick_op(OP_ADD, 8), pick_operand(), pick_operand());
        repeat (30) run_op(pick_op(OP_MUL, 3), pick_operand(), pick_operand());

        // Accumulate chains on random HI/LO
        repeat (6) begin
            run_op(OP_MTHI, pick_operand(), pick_operand());
            run_op(OP_MTLO, pick_operand(), pick_operand());
            repeat (6) run_op(pick_op(OP_MADD, 4), pick_operand(), pick_operand());
        end

        repeat (10) begin
            a = pick_operand();
            run_op(OP_MTHI, a, pick_operand());
            run_op(OP_MFHI, pick_operand(), pick_operand());
            reg_read(REG_RESULT, a, "mfhi_round_trip");
            a = pick_operand();
            run_op(OP_MTLO, a, pick_operand());
            run_op(OP_MFLO, pick_operand(), pick_operand());
            reg_read(REG_RESULT, a, "mflo_round_trip");
        end

        // Illegal codes of zero, past the last op and with stray upper bits
        reg_write(REG_CMD, 32'd0, 1'b1, 0);
        repeat (4) reg_write(REG_CMD, 32'd27 + $unsigned($random(seed)) % 32'd37, 1'b1, 0);
        reg_write(REG_CMD, 32'h0000_0100 | word_t'(OP_ADD), 1'b1, 0);
        verify_state();

        bad_access(1'b1, 8'h1C);
        bad_access(1'b0, 8'h02);
        repeat (6) begin
            v = 32'h1C + $unsigned($random(seed)) % 32'd228;
            bad_access(v[0], v[7:0]);
        end

        if (n_checks > 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            abort("no checks were executed");
        end
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+bench
logic/exu_pkg.sv
logic/exu_cmd_if.sv
logic/apb_exu_regs.sv
logic/alu_core.sv
logic/mul_acc_unit.sv
logic/exec_top.sv
bench/tb_exec_top.sv

// ==== run.sh ====
#!/bin/sh
# Build the execution unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_exec_top -o sim_tb \
    && ./obj_dir/sim_tb \
    || { echo "Simulation run returned a failing status"; exit 1; }
